// File: logic/core_pkg.sv
/* core datapath widths shared by the memory stage.
   rv32 only, so every data and address word is 32 bits. */

package core_pkg;

    // architectural word width
    localparam int XLEN = 32;

    // register file index width, 32 integer registers
    localparam int REG_IDX_W = 5;

    // one data or address word
    typedef logic [XLEN-1:0] xlen_t;

    // destination register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage : core_pkg

// File: logic/mem_pkg.sv
/* load/store encodings and data memory geometry.
   the ram is private to this stage and word addressed, MEM_WORDS deep. */

package mem_pkg;

    // data ram depth in 32-bit words
    localparam int MEM_WORDS = 1024;

    // word index width into the ram
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

    // byte lanes per word
    localparam int MEM_LANES = 4;

    // load kind, any nonzero value means a load
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LBU  = 3'd4,
        LOAD_LHU  = 3'd5
    } load_type_e;

    // store kind, any nonzero value means a store
    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_type_e;

    // one write enable per byte lane
    typedef logic [MEM_LANES-1:0] byte_mask_t;

    // word index into the data ram
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage : mem_pkg

// File: logic/store_align.sv
/* store lane alignment, purely combinational.
   addresses must be aligned to the access size. */

`timescale 1ns/1ns

module store_align
    import core_pkg::*;
    import mem_pkg::*;
(
    input  store_type_e store_type_i,
    input  logic [1:0]  addr_lo_i,
    input  xlen_t       store_data_i,
    output byte_mask_t  wmask_o,
    output xlen_t       wdata_o
);

    // low bytes moved up to the addressed lane
    assign wdata_o = store_data_i << {addr_lo_i, 3'b000};

    always_comb begin
        case (store_type_i)
            STORE_SB: wmask_o = byte_mask_t'(4'b0001 << addr_lo_i);
            STORE_SH: wmask_o = byte_mask_t'(4'b0011 << addr_lo_i);
            STORE_SW: wmask_o = 4'b1111;
            default:  wmask_o = 4'b0000;
        endcase
    end

    // halfwords on even bytes, words on word boundaries
    always_comb begin
        if (store_type_i == STORE_SH) begin
            a_sh_aligned: assert #0 (addr_lo_i[0] == 1'b0)
                else $error("misaligned halfword store, addr_lo %0d", addr_lo_i);
        end
        if (store_type_i == STORE_SW) begin
            a_sw_aligned: assert #0 (addr_lo_i == 2'b00)
                else $error("misaligned word store, addr_lo %0d", addr_lo_i);
        end
    end

endmodule : store_align

// File: logic/load_extend.sv
/* load lane select and extension, purely combinational.
   addresses must be aligned to the access size. */

`timescale 1ns/1ns

module load_extend
    import core_pkg::*;
    import mem_pkg::*;
(
    input  load_type_e load_type_i,
    input  logic [1:0] addr_lo_i,
    input  xlen_t      rdata_i,
    output xlen_t      rdata_o
);

    xlen_t lane_data;

    // addressed lane brought down to bit 0
    assign lane_data = rdata_i >> {addr_lo_i, 3'b000};

    always_comb begin
        case (load_type_i)
            LOAD_LB:  rdata_o = {{24{lane_data[7]}}, lane_data[7:0]};
            LOAD_LH:  rdata_o = {{16{lane_data[15]}}, lane_data[15:0]};
            LOAD_LBU: rdata_o = {24'b0, lane_data[7:0]};
            LOAD_LHU: rdata_o = {16'b0, lane_data[15:0]};
            // lw and non-loads see the raw word
            default:  rdata_o = rdata_i;
        endcase
    end

    always_comb begin
        if (load_type_i == LOAD_LH || load_type_i == LOAD_LHU) begin
            a_lh_aligned: assert #0 (addr_lo_i[0] == 1'b0)
                else $error("misaligned halfword load, addr_lo %0d", addr_lo_i);
        end
        if (load_type_i == LOAD_LW) begin
            a_lw_aligned: assert #0 (addr_lo_i == 2'b00)
                else $error("misaligned word load, addr_lo %0d", addr_lo_i);
        end
    end

endmodule : load_extend

// File: logic/data_sram.sv
/* single-port data ram, one cycle read latency, byte-masked write.
   contents come up undefined; read and write share one address. */

`timescale 1ns/1ns

module data_sram
    import core_pkg::*;
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       we_i,
    input  logic       re_i,
    input  mem_addr_t  addr_i,
    input  byte_mask_t wmask_i,
    input  xlen_t      wdata_i,
    output xlen_t      rdata_o
);

    xlen_t mem [MEM_WORDS];

    // only enabled lanes are touched
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int lane = 0; lane < MEM_LANES; lane++) begin
                if (wmask_i[lane]) begin
                    mem[addr_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
                end
            end
        end
    end

    // read register holds its value between reads
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule : data_sram

// File: logic/lsu.sv
/* memory stage control, fixed two cycles per instruction, no back-pressure.
   request fields must stay stable from valid_i until the lsu_valid_o pulse. */

`timescale 1ns/1ns

module lsu
    import core_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid_i,
    input  xlen_t       alu_result_i,
    input  load_type_e  load_type_i,
    input  store_type_e store_type_i,
    input  xlen_t       load_data_i,
    input  logic        wd_i,
    input  reg_idx_t    wreg_i,
    input  xlen_t       csr_wdata_i,
    output logic        ram_we_o,
    output logic        ram_re_o,
    output logic        memory_inst_o,
    output logic        lsu_valid_o,
    output xlen_t       wdata_o,
    output logic        wd_o,
    output reg_idx_t    wreg_o,
    output xlen_t       csr_wdata_o
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } lsu_state_e;

    lsu_state_e state_q;
    lsu_state_e state_d;
    logic       is_load;
    logic       is_store;

    assign is_load  = (load_type_i != LOAD_NONE);
    assign is_store = (store_type_i != STORE_NONE);

    // valid_i only matters in IDLE
    always_comb begin
        case (state_q)
            IDLE:    state_d = valid_i ? ACCESS : IDLE;
            ACCESS:  state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= IDLE;
            lsu_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            // pulse for the one cycle spent in DONE
            lsu_valid_o <= (state_q == ACCESS);
        end
    end

    // ram strobes for the access cycle, the ram acts on the next edge
    assign ram_we_o = (state_q == ACCESS) && is_store;
    assign ram_re_o = (state_q == ACCESS) && is_load;

    assign memory_inst_o = (state_q == DONE) && (is_load || is_store);

    // ram read word is valid in DONE
    assign wdata_o = is_load ? load_data_i : alu_result_i;

    // write-back fields go straight through
    assign wd_o        = wd_i;
    assign wreg_o      = wreg_i;
    assign csr_wdata_o = csr_wdata_i;

    // decode upstream must never ask for both at once
    a_not_load_and_store: assert property (
        @(posedge clk) disable iff (rst)
        (state_q != IDLE) |-> !(is_load && is_store)
    ) else $error("load and store requested together");

    a_single_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        lsu_valid_o |=> !lsu_valid_o
    ) else $error("lsu_valid_o high for two cycles");

endmodule : lsu

// File: logic/mem_stage_top.sv
/* memory stage top: control, lane alignment, extension and private ram.
   ram index is alu_result_i[11:2], so only the low 4 KiB are reachable. */

`timescale 1ns/1ns

module mem_stage_top
    import core_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid_i,
    input  xlen_t       alu_result_i,
    input  load_type_e  load_type_i,
    input  store_type_e store_type_i,
    input  xlen_t       store_data_i,
    input  logic        wd_i,
    input  reg_idx_t    wreg_i,
    input  xlen_t       csr_wdata_i,
    output logic        memory_inst_o,
    output logic        lsu_valid_o,
    output xlen_t       wdata_o,
    output logic        wd_o,
    output reg_idx_t    wreg_o,
    output xlen_t       csr_wdata_o
);

    logic       ram_we;
    logic       ram_re;
    mem_addr_t  ram_addr;
    byte_mask_t byte_mask;
    xlen_t      ram_wdata;
    xlen_t      ram_rdata;
    xlen_t      load_data;

    // word index from the byte address
    assign ram_addr = alu_result_i[11:2];

    lsu i_lsu (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .alu_result_i  (alu_result_i),
        .load_type_i   (load_type_i),
        .store_type_i  (store_type_i),
        .load_data_i   (load_data),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .csr_wdata_i   (csr_wdata_i),
        .ram_we_o      (ram_we),
        .ram_re_o      (ram_re),
        .memory_inst_o (memory_inst_o),
        .lsu_valid_o   (lsu_valid_o),
        .wdata_o       (wdata_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .csr_wdata_o   (csr_wdata_o)
    );

    store_align i_store_align (
        .store_type_i (store_type_i),
        .addr_lo_i    (alu_result_i[1:0]),
        .store_data_i (store_data_i),
        .wmask_o      (byte_mask),
        .wdata_o      (ram_wdata)
    );

    data_sram i_data_sram (
        .clk     (clk),
        .we_i    (ram_we),
        .re_i    (ram_re),
        .addr_i  (ram_addr),
        .wmask_i (byte_mask),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    load_extend i_load_extend (
        .load_type_i (load_type_i),
        .addr_lo_i   (alu_result_i[1:0]),
        .rdata_i     (ram_rdata),
        .rdata_o     (load_data)
    );

endmodule : mem_stage_top

// File: bench/mem_stage_tb.sv
/* memory stage testbench with accesses in a 64-word window at address 0.
   every access is aligned; ram words are written before they are read. */

`timescale 1ns/1ns

module mem_stage_tb
    import core_pkg::*;
    import mem_pkg::*;
();

    localparam int WINDOW_WORDS = 64;
    localparam int NUM_RANDOM   = 300;
    // init + readback, lane stores, extension, non-memory, random
    localparam int NUM_OPS      = 2 * WINDOW_WORDS + 48 + 52 + 8 + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = NUM_OPS * 4 + 100;

    logic        clk;
    logic        rst;
    logic        valid_i;
    xlen_t       alu_result_i;
    load_type_e  load_type_i;
    store_type_e store_type_i;
    xlen_t       store_data_i;
    logic        wd_i;
    reg_idx_t    wreg_i;
    xlen_t       csr_wdata_i;
    logic        memory_inst_o;
    logic        lsu_valid_o;
    xlen_t       wdata_o;
    logic        wd_o;
    reg_idx_t    wreg_o;
    xlen_t       csr_wdata_o;

    logic [15:0] lfsr;
    logic [7:0]  shadow [4*WINDOW_WORDS];
    string       cur_name;
    logic        op_pending;
    xlen_t       exp_wdata;
    logic        exp_mem_inst;
    logic        exp_wd;
    reg_idx_t    exp_wreg;
    xlen_t       exp_csr;
    int          op_count;
    int          pulse_count;
    int          cycle_count = 0;

    mem_stage_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .alu_result_i  (alu_result_i),
        .load_type_i   (load_type_i),
        .store_type_i  (store_type_i),
        .store_data_i  (store_data_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .csr_wdata_i   (csr_wdata_i),
        .memory_inst_o (memory_inst_o),
        .lsu_valid_o   (lsu_valid_o),
        .wdata_o       (wdata_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .csr_wdata_o   (csr_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic xlen_t rand_bits(input int n);
        xlen_t val;
        logic  fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic xlen_t fill_word(input int addr);
        return 32'h9e37_0000 ^ (xlen_t'(addr) * 32'h0001_0101);
    endfunction

    // expected write-back value from the little endian shadow bytes
    function automatic xlen_t ref_result(input load_type_e ld, input xlen_t alu);
        int a;
        a = alu[7:0];
        case (ld)
            LOAD_LB:  return {{24{shadow[a][7]}}, shadow[a]};
            LOAD_LBU: return {24'b0, shadow[a]};
            LOAD_LH:  return {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
            LOAD_LHU: return {16'b0, shadow[a+1], shadow[a]};
            LOAD_LW:  return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
            default:  return alu;
        endcase
    endfunction

    task automatic shadow_store(input store_type_e st, input xlen_t alu, input xlen_t data);
        int a;
        a = alu[7:0];
        if (st != STORE_NONE) begin
            shadow[a] = data[7:0];
        end
        if (st == STORE_SH || st == STORE_SW) begin
            shadow[a+1] = data[15:8];
        end
        if (st == STORE_SW) begin
            shadow[a+2] = data[23:16];
            shadow[a+3] = data[31:24];
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic compare_reg(input string name, input reg_idx_t expected,
                               input reg_idx_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // one instruction starting 1 ns after a rising edge
    task automatic run_op(input string name, input load_type_e ld, input store_type_e st,
                          input xlen_t alu, input xlen_t data, input logic hold);
        int waits;
        cur_name     = name;
        exp_wdata    = ref_result(ld, alu);
        exp_mem_inst = (ld != LOAD_NONE) || (st != STORE_NONE);
        shadow_store(st, alu, data);
        alu_result_i = alu;
        load_type_i  = ld;
        store_type_i = st;
        store_data_i = data;
        wd_i         = rand_bits(1);
        wreg_i       = rand_bits(5);
        csr_wdata_i  = rand_bits(32);
        exp_wd       = wd_i;
        exp_wreg     = wreg_i;
        exp_csr      = csr_wdata_i;
        op_pending   = 1'b1;
        op_count++;
        valid_i      = 1'b1;
        waits        = 0;
        @(posedge clk);
        #1;
        // held valid_i must be ignored while busy
        if (!hold) begin
            valid_i = 1'b0;
        end
        while (op_pending && waits < 4) begin
            @(posedge clk);
            #1;
            waits++;
        end
        valid_i = 1'b0;
        if (op_pending) begin
            abort_run($sformatf("no lsu_valid_o pulse for %s", name));
        end
        if (waits != 2) begin
            abort_run($sformatf("lsu_valid_o for %s came %0d cycles after sampling, not 2",
                                name, waits));
        end
    endtask

    task automatic run_random_op();
        logic [2:0]  sel;
        logic [1:0]  lane;
        load_type_e  ld;
        store_type_e st;
        xlen_t       alu;
        sel = rand_bits(3);
        ld  = LOAD_NONE;
        st  = STORE_NONE;
        case (sel)
            3'd1: st = STORE_SB;
            3'd2: st = STORE_SH;
            3'd3: st = STORE_SW;
            3'd4: ld = LOAD_LB;
            3'd5: ld = LOAD_LH;
            3'd6: ld = LOAD_LW;
            3'd7: ld = rand_bits(1) ? LOAD_LBU : LOAD_LHU;
            default: ;
        endcase
        lane = rand_bits(2);
        if (st == STORE_SH || ld == LOAD_LH || ld == LOAD_LHU) begin
            lane[0] = 1'b0;
        end
        if (st == STORE_SW || ld == LOAD_LW) begin
            lane = 2'b00;
        end
        alu = (rand_bits(6) << 2) | lane;
        if (sel == 3'd0) begin
            alu = rand_bits(32);
        end
        run_op("random", ld, st, alu, rand_bits(32), rand_bits(1));
    endtask

    // checks every done pulse and that memory_inst_o stays low otherwise
    always @(negedge clk) begin
        if (!rst) begin
            if (lsu_valid_o) begin
                pulse_count++;
                if (!op_pending) begin
                    abort_run("lsu_valid_o pulsed with no instruction outstanding");
                end
                compare_word({cur_name, " wdata_o"}, exp_wdata, wdata_o);
                compare_bit({cur_name, " memory_inst_o"}, exp_mem_inst, memory_inst_o);
                compare_bit({cur_name, " wd_o"}, exp_wd, wd_o);
                compare_reg({cur_name, " wreg_o"}, exp_wreg, wreg_o);
                compare_word({cur_name, " csr_wdata_o"}, exp_csr, csr_wdata_o);
                op_pending = 1'b0;
            end else begin
                compare_bit({cur_name, " memory_inst_o outside done"}, 1'b0, memory_inst_o);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        xlen_t base;
        lfsr         = 16'd4;
        rst          = 1'b1;
        valid_i      = 1'b0;
        alu_result_i = '0;
        load_type_i  = LOAD_NONE;
        store_type_i = STORE_NONE;
        store_data_i = '0;
        wd_i         = 1'b0;
        wreg_i       = '0;
        csr_wdata_i  = '0;
        op_pending   = 1'b0;
        op_count     = 0;
        pulse_count  = 0;
        cur_name     = "idle";
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (10) begin
            @(negedge clk);
            compare_bit("idle lsu_valid_o", 1'b0, lsu_valid_o);
            compare_bit("idle memory_inst_o", 1'b0, memory_inst_o);
        end
        @(posedge clk);
        #1;
        // whole window written first since the ram has no reset value
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            run_op("sw init", LOAD_NONE, STORE_SW, xlen_t'(4 * w), fill_word(4 * w), 1'b0);
        end
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            run_op("lw readback", LOAD_LW, STORE_NONE, xlen_t'(4 * w), '0, 1'b0);
        end
        // word read back after every narrow store
        for (int w = 0; w < 4; w++) begin
            base = xlen_t'(4 * (16 + w));
            for (int lane = 0; lane < 4; lane++) begin
                run_op("sb lane", LOAD_NONE, STORE_SB, base + lane, rand_bits(32), 1'b0);
                run_op("lw after sb", LOAD_LW, STORE_NONE, base, '0, 1'b0);
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                run_op("sh lane", LOAD_NONE, STORE_SH, base + lane, rand_bits(32), 1'b0);
                run_op("lw after sh", LOAD_LW, STORE_NONE, base, '0, 1'b0);
            end
        end
        // bytes 7e f1 80 7f mix both sign bits
        for (int w = 0; w < 4; w++) begin
            base = xlen_t'(4 * (32 + w));
            run_op("sw ext", LOAD_NONE, STORE_SW, base, 32'h7f80_f17e ^ xlen_t'(w), 1'b0);
            for (int lane = 0; lane < 4; lane++) begin
                run_op("lb", LOAD_LB, STORE_NONE, base + lane, '0, 1'b0);
                run_op("lbu", LOAD_LBU, STORE_NONE, base + lane, '0, 1'b0);
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                run_op("lh", LOAD_LH, STORE_NONE, base + lane, '0, 1'b0);
                run_op("lhu", LOAD_LHU, STORE_NONE, base + lane, '0, 1'b0);
            end
        end
        for (int i = 0; i < 8; i++) begin
            run_op("alu passthrough", LOAD_NONE, STORE_NONE, rand_bits(32), rand_bits(32), 1'b0);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_random_op();
        end
        repeat (4) @(posedge clk);
        if (pulse_count == op_count && op_count == NUM_OPS) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("saw %0d done pulses for %0d instructions", pulse_count, op_count);
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule : mem_stage_tb

// File: project.f
logic/core_pkg.sv
logic/mem_pkg.sv
logic/store_align.sv
logic/load_extend.sv
logic/data_sram.sv
logic/lsu.sv
logic/mem_stage_top.sv
bench/mem_stage_tb.sv
